// File: all.f
soc_pkg.sv
apb_if.sv
apb_bridge.sv
apb_splitter.sv
mtimer.sv
uart_tx_apb.sv
periph_soc.sv
periph_soc_properties.sv
tb_periph_soc.sv

// File: Makefile
# Verilator flow for the peripheral subsystem testbench

TOP := tb_periph_soc

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

obj_dir/V$(TOP): all.f *.sv
	verilator --binary --timing --assert -f all.f --top-module $(TOP)

# a crash or assertion stop also counts as failure
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "ERRORS FOUND" >> sim.log
	cat sim.log
	! grep -q "ERRORS FOUND" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_periph_soc.sv
// ----------------------------------------------------------
// testbench for the peripheral subsystem
// clock, reset and a table of register accesses
// interrupt, timer count and uart frame checks
// watchdog and closing error counts
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_periph_soc
	import soc_pkg::*;
();

	localparam int CLK_MHZ        = 4;
	localparam int UART_DIV_RESET = 8;
	// timer ticks between the two mtime reads
	localparam int N_TICKS        = 20;
	localparam int RSP_LIMIT      = 40 * UART_DIV_RESET;
	// bit period written to DIV before the frames
	localparam int TEST_DIV       = 6;

	logic  clk;
	logic  rst_n;
	logic  i_req_valid;
	logic  i_req_write;
	addr_t i_req_addr;
	data_t i_req_wdata;
	logic  i_dbg_halt;
	logic  o_busy;
	logic  o_rsp_valid;
	data_t o_rsp_rdata;
	logic  o_rsp_err;
	logic  o_soft_irq;
	logic  o_timer_irq;
	logic  o_uart_tx;

	// stimulus table, one entry per access
	logic  tbl_wr[$];
	addr_t tbl_addr[$];
	data_t tbl_wdata[$];
	data_t tbl_rdata[$];
	bit    tbl_err[$];

	// bytes seen on the serial line
	logic [7:0] rx_q[$];
	int         cur_div;
	int         data_errs;
	int         flag_errs;
	int         irq_errs;
	int         other_errs;

	periph_soc #(
		.CLK_MHZ        (CLK_MHZ),
		.UART_DIV_RESET (UART_DIV_RESET)
	) i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_req_valid (i_req_valid),
		.i_req_write (i_req_write),
		.i_req_addr  (i_req_addr),
		.i_req_wdata (i_req_wdata),
		.i_dbg_halt  (i_dbg_halt),
		.o_busy      (o_busy),
		.o_rsp_valid (o_rsp_valid),
		.o_rsp_rdata (o_rsp_rdata),
		.o_rsp_err   (o_rsp_err),
		.o_soft_irq  (o_soft_irq),
		.o_timer_irq (o_timer_irq),
		.o_uart_tx   (o_uart_tx)
	);

	bind apb_bridge periph_soc_properties u_props (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_state     (state_q),
		.i_psel      (m_apb.psel),
		.i_penable   (m_apb.penable),
		.i_rsp_valid (o_rsp_valid),
		.i_busy      (o_busy)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ----------------------------------------------------------
	// compare tasks
	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			data_errs++;
			$display("FAIL %s got 0x%08h exp 0x%08h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_err(input string name, input bit got, input bit exp);
		if (got !== exp) begin
			flag_errs++;
			$display("FAIL %s got 0x%0h exp 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_irq(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			irq_errs++;
			$display("FAIL %s got 0x%0h exp 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic note_failure(input string msg);
		other_errs++;
		$display("%s at %0t", msg, $time);
	endtask

	task automatic add_row(input logic wr, input addr_t addr, input data_t wdata,
			input data_t rdata, input bit err);
		tbl_wr.push_back(wr);
		tbl_addr.push_back(addr);
		tbl_wdata.push_back(wdata);
		tbl_rdata.push_back(rdata);
		tbl_err.push_back(err);
	endtask

	// ----------------------------------------------------------
	// one request, lat counts cycles from the sampling edge
	task automatic access(input logic wr, input addr_t addr, input data_t wdata,
			output data_t rdata, output bit err, output int lat);
		bit got;
		got   = 1'b0;
		lat   = 0;
		rdata = '0;
		err   = 1'b0;
		@(posedge clk);
		i_req_valid <= 1'b1;
		i_req_write <= wr;
		i_req_addr  <= addr;
		i_req_wdata <= wdata;
		@(posedge clk);
		i_req_valid <= 1'b0;
		while (!got && lat < RSP_LIMIT) begin
			@(negedge clk);
			lat++;
			if (o_rsp_valid === 1'b1) begin
				got   = 1'b1;
				rdata = o_rsp_rdata;
				err   = o_rsp_err;
				if (o_busy !== 1'b0) begin
					note_failure("o_busy still high in the response cycle");
				end
			end else if (o_busy !== 1'b1) begin
				note_failure("o_busy dropped while a request was pending");
			end
		end
		if (!got) begin
			note_failure($sformatf("no response to request at address 0x%04h", addr));
		end
	endtask

	task automatic write_reg(input addr_t addr, input data_t wdata);
		data_t rd;
		bit    er;
		int    lat;
		access(1'b1, addr, wdata, rd, er, lat);
		check_data("o_rsp_rdata", rd, '0);
		check_err("o_rsp_err", er, 1'b0);
	endtask

	task automatic read_reg(input addr_t addr, output data_t rd);
		bit er;
		int lat;
		access(1'b0, addr, '0, rd, er, lat);
		check_err("o_rsp_err", er, 1'b0);
	endtask

	task automatic run_row(input int idx);
		data_t rd;
		bit    er;
		int    lat;
		access(tbl_wr[idx], tbl_addr[idx], tbl_wdata[idx], rd, er, lat);
		check_data("o_rsp_rdata", rd, tbl_rdata[idx]);
		check_err("o_rsp_err", er, tbl_err[idx]);
		// nothing stalls in the table
		if (lat != 3) begin
			note_failure($sformatf("row %0d answered after %0d cycles, expected 3", idx, lat));
		end
	endtask

	task automatic wait_bytes(input int n);
		int waited;
		waited = 0;
		while (rx_q.size() < n && waited < 20 * cur_div) begin
			@(negedge clk);
			waited++;
		end
		if (rx_q.size() < n) begin
			note_failure($sformatf("only %0d uart bytes seen, expected %0d", rx_q.size(), n));
		end
	endtask

	// ----------------------------------------------------------
	// uart line monitor, samples at bit centers
	initial begin : uart_monitor
		logic [7:0] shreg;
		wait (rst_n === 1'b1);
		forever begin
			@(negedge o_uart_tx);
			repeat (cur_div / 2) @(negedge clk);
			if (o_uart_tx !== 1'b0) begin
				note_failure("uart start bit not low at its center");
			end
			for (int i = 0; i < 8; i++) begin
				repeat (cur_div) @(negedge clk);
				shreg[i] = o_uart_tx;
			end
			repeat (cur_div) @(negedge clk);
			if (o_uart_tx !== 1'b1) begin
				note_failure("uart stop bit not high at its center");
			end
			rx_q.push_back(shreg);
		end
	end

	// bounded by the table length and the uart frames
	initial begin : watchdog
		int limit;
		#1;
		limit = tbl_wr.size() * (4 + 10 * UART_DIV_RESET) + 60 * UART_DIV_RESET
			+ N_TICKS * CLK_MHZ + 200;
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", limit);
		$display("ERRORS FOUND");
		$finish;
	end

	// ----------------------------------------------------------
	// main sequence
	initial begin : main
		data_t rd;
		data_t t0;
		data_t t1;
		data_t delta;
		data_t w0;
		data_t w1;
		data_t w2;
		bit    er;
		int    lat;
		int    total;
		rst_n       = 1'b0;
		i_req_valid = 1'b0;
		i_req_write = 1'b0;
		i_req_addr  = '0;
		i_req_wdata = '0;
		i_dbg_halt  = 1'b1;
		cur_div     = UART_DIV_RESET;
		data_errs   = 0;
		flag_errs   = 0;
		irq_errs    = 0;
		other_errs  = 0;
		void'($urandom(1));

		// timer halves under halt, then error and map rows
		w0 = $urandom;
		add_row(1'b1, 16'h0008, w0, '0, 1'b0);
		add_row(1'b0, 16'h0008, '0, w0, 1'b0);
		w0 = $urandom;
		add_row(1'b1, 16'h000C, w0, '0, 1'b0);
		add_row(1'b0, 16'h000C, '0, w0, 1'b0);
		w0 = $urandom;
		add_row(1'b1, 16'h0010, w0, '0, 1'b0);
		add_row(1'b0, 16'h0010, '0, w0, 1'b0);
		w0 = $urandom;
		add_row(1'b1, 16'h0014, w0, '0, 1'b0);
		add_row(1'b0, 16'h0014, '0, w0, 1'b0);
		add_row(1'b0, 16'h0018, '0, '0, 1'b1);
		add_row(1'b0, 16'h0000, '0, 32'h1, 1'b0);
		add_row(1'b0, 16'h8000, '0, '0, 1'b1);
		add_row(1'b1, 16'hC004, $urandom, '0, 1'b1);
		add_row(1'b0, 16'h4008, '0, data_t'(UART_DIV_RESET), 1'b0);
		add_row(1'b0, 16'h4004, '0, '0, 1'b0);

		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_irq("o_timer_irq", o_timer_irq, 1'b0);
		check_irq("o_soft_irq", o_soft_irq, 1'b0);
		check_irq("o_uart_tx", o_uart_tx, 1'b1);

		for (int i = 0; i < tbl_wr.size(); i++) begin
			run_row(i);
		end

		// interrupts under halt
		write_reg(16'h000C, 32'h0);
		write_reg(16'h0008, 32'h0000_1000);
		write_reg(16'h0014, 32'h0);
		write_reg(16'h0010, 32'h0000_1000);
		repeat (2) @(negedge clk);
		check_irq("o_timer_irq", o_timer_irq, 1'b1);
		write_reg(16'h0010, 32'h0000_1001);
		repeat (2) @(negedge clk);
		check_irq("o_timer_irq", o_timer_irq, 1'b0);
		write_reg(16'h0004, 32'h1);
		check_irq("o_soft_irq", o_soft_irq, 1'b1);
		write_reg(16'h0004, 32'h0);
		check_irq("o_soft_irq", o_soft_irq, 1'b0);

		// ----------------------------------------------------------
		// counting, strobes N_TICKS microseconds apart
		write_reg(16'h0008, 32'h0);
		write_reg(16'h0000, 32'h1);
		@(posedge clk);
		i_dbg_halt <= 1'b0;
		read_reg(16'h0008, t0);
		repeat (N_TICKS * CLK_MHZ - 4) @(posedge clk);
		read_reg(16'h0008, t1);
		@(posedge clk);
		i_dbg_halt <= 1'b1;
		delta = t1 - t0;
		if (delta < data_t'(N_TICKS - 1) || delta > data_t'(N_TICKS + 1)) begin
			check_data("mtime_delta", delta, data_t'(N_TICKS));
		end

		// new bit period, monitor follows it
		write_reg(16'h4008, data_t'(TEST_DIV));
		read_reg(16'h4008, rd);
		check_data("div_readback", rd, data_t'(TEST_DIV));
		cur_div = TEST_DIV;

		// single uart frame
		w0 = $urandom;
		write_reg(16'h4000, w0);
		read_reg(16'h4004, rd);
		check_data("status_busy", rd, 32'h1);
		wait_bytes(1);
		repeat (cur_div) @(negedge clk);
		read_reg(16'h4004, rd);
		check_data("status_busy", rd, 32'h0);

		// ----------------------------------------------------------
		// back to back frames, second write held off
		w1 = $urandom;
		w2 = $urandom;
		write_reg(16'h4000, w1);
		access(1'b1, 16'h4000, w2, rd, er, lat);
		check_err("o_rsp_err", er, 1'b0);
		if (lat <= 3) begin
			note_failure("second TXDATA write was answered without a stall");
		end
		if (rx_q.size() != 2) begin
			note_failure("second TXDATA write accepted before the first frame ended");
		end
		wait_bytes(3);
		if (rx_q.size() >= 3) begin
			check_data("uart_byte0", {24'h0, rx_q[0]}, {24'h0, w0[7:0]});
			check_data("uart_byte1", {24'h0, rx_q[1]}, {24'h0, w1[7:0]});
			check_data("uart_byte2", {24'h0, rx_q[2]}, {24'h0, w2[7:0]});
		end

		repeat (4) @(negedge clk);
		total = data_errs + flag_errs + irq_errs + other_errs;
		$display("error counts: data %0d, flag %0d, irq %0d, other %0d",
			data_errs, flag_errs, irq_errs, other_errs);
		if (total == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: periph_soc_properties.sv
// ----------------------------------------------------------
// concurrent checks bound into the APB bridge
// phase order, enable without select
// response pulse width and busy after reset
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module periph_soc_properties
	import soc_pkg::*;
(
	input logic       clk,
	input logic       rst_n,
	input apb_state_e i_state,
	input logic       i_psel,
	input logic       i_penable,
	input logic       i_rsp_valid,
	input logic       i_busy
);

	// setup lasts exactly one cycle
	a_setup_access: assert property (@(posedge clk) disable iff (!rst_n)
		(i_state == SETUP) |=> (i_state == ACCESS))
		else $error("bridge left SETUP without entering ACCESS");

	a_enable_sel: assert property (@(posedge clk) disable iff (!rst_n)
		i_penable |-> i_psel)
		else $error("penable high without psel");

	// response is a one-cycle pulse
	a_rsp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		i_rsp_valid |=> !i_rsp_valid)
		else $error("o_rsp_valid held for more than one cycle");

	a_busy_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !i_busy)
		else $error("o_busy high right after reset");

endmodule

`default_nettype wire

// File: periph_soc.sv
// ----------------------------------------------------------
// peripheral subsystem top level
// request port -> APB bridge -> splitter -> timer, uart
// plain ports outside, APB bundles inside
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module periph_soc
	import soc_pkg::*;
#(
	parameter int CLK_MHZ        = 4,
	parameter int UART_DIV_RESET = 8
) (
	input  logic  clk,
	input  logic  rst_n,

	// register-access port
	input  logic  i_req_valid,
	input  logic  i_req_write,
	input  addr_t i_req_addr,
	input  data_t i_req_wdata,
	input  logic  i_dbg_halt,
	output logic  o_busy,
	output logic  o_rsp_valid,
	output data_t o_rsp_rdata,
	output logic  o_rsp_err,

	// interrupt levels and serial line
	output logic  o_soft_irq,
	output logic  o_timer_irq,
	output logic  o_uart_tx
);

	apb_if bridge_bus ();
	apb_if timer_bus ();
	apb_if uart_bus ();

	// ----------------------------------------------------------
	// request capture and APB sequencing
	apb_bridge u_bridge (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_req_valid (i_req_valid),
		.i_req_write (i_req_write),
		.i_req_addr  (i_req_addr),
		.i_req_wdata (i_req_wdata),
		.o_busy      (o_busy),
		.o_rsp_valid (o_rsp_valid),
		.o_rsp_rdata (o_rsp_rdata),
		.o_rsp_err   (o_rsp_err),
		.m_apb       (bridge_bus.master)
	);

	// address decode
	apb_splitter u_splitter (
		.s_apb   (bridge_bus.slave),
		.m_timer (timer_bus.master),
		.m_uart  (uart_bus.master)
	);

	// ----------------------------------------------------------
	// peripherals
	mtimer #(
		.CLK_MHZ (CLK_MHZ)
	) u_timer (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_dbg_halt  (i_dbg_halt),
		.s_apb       (timer_bus.slave),
		.o_soft_irq  (o_soft_irq),
		.o_timer_irq (o_timer_irq)
	);

	uart_tx_apb #(
		.UART_DIV_RESET (UART_DIV_RESET)
	) u_uart (
		.clk   (clk),
		.rst_n (rst_n),
		.s_apb (uart_bus.slave),
		.o_tx  (o_uart_tx)
	);

endmodule

`default_nettype wire

// File: uart_tx_apb.sv
// ----------------------------------------------------------
// transmit-only UART on APB
// 8N1 frame, bit period set by the DIV register
// TXDATA write while busy stalls pready until idle
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module uart_tx_apb
	import soc_pkg::*;
#(
	parameter int UART_DIV_RESET = 8
) (
	input  logic clk,
	input  logic rst_n,
	apb_if.slave s_apb,
	output logic o_tx
);

	// start, eight data, stop
	localparam int FRAME_BITS = 10;
	localparam int DIV_W      = 16;

	logic [DIV_W-1:0]      div_q;
	logic [DIV_W-1:0]      baud_cnt_q;
	logic [3:0]            bits_left_q;
	logic [FRAME_BITS-1:0] shift_q;
	logic                  busy;

	uart_reg_e reg_off;
	logic      off_hi_zero;
	logic      tx_wr;
	logic      load;
	logic      div_wr;
	logic      reg_hit;
	data_t     rdata;

	// ----------------------------------------------------------
	// bus decode
	assign reg_off     = uart_reg_e'(s_apb.paddr[3:0]);
	assign off_hi_zero = ~|s_apb.paddr[ADDR_W-1:4];
	assign busy        = |bits_left_q;

	// TXDATA write in setup or access
	assign tx_wr  = s_apb.psel && s_apb.pwrite && off_hi_zero && (reg_off == TXDATA);
	assign load   = tx_wr && s_apb.penable && !busy;
	assign div_wr = s_apb.psel && s_apb.penable && s_apb.pwrite && off_hi_zero
		&& (reg_off == DIV);

	// ----------------------------------------------------------
	// bit timing and shifter
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_q       <= DIV_W'(UART_DIV_RESET);
			baud_cnt_q  <= '0;
			bits_left_q <= '0;
			// all ones keeps the line idle high
			shift_q     <= '1;
		end else begin
			if (div_wr) begin
				div_q <= s_apb.pwdata[DIV_W-1:0];
			end
			if (load) begin
				shift_q     <= {1'b1, s_apb.pwdata[7:0], 1'b0};
				bits_left_q <= 4'(FRAME_BITS);
				baud_cnt_q  <= div_q - 1'b1;
			end else if (busy) begin
				if (baud_cnt_q == '0) begin
					// next bit, shift in idle level
					shift_q     <= {1'b1, shift_q[FRAME_BITS-1:1]};
					bits_left_q <= bits_left_q - 1'b1;
					baud_cnt_q  <= div_q - 1'b1;
				end else begin
					baud_cnt_q <= baud_cnt_q - 1'b1;
				end
			end
		end
	end

	assign o_tx = shift_q[0];

	// ----------------------------------------------------------
	// read mux
	always_comb begin
		rdata   = '0;
		reg_hit = 1'b1;
		case (reg_off)
			TXDATA:  rdata = '0;
			STATUS:  rdata = {{(DATA_W-1){1'b0}}, busy};
			DIV:     rdata = {{(DATA_W-DIV_W){1'b0}}, div_q};
			default: reg_hit = 1'b0;
		endcase
	end

	// only back-pressure in the design
	assign s_apb.pready  = !(tx_wr && busy);
	assign s_apb.prdata  = rdata;
	assign s_apb.pslverr = s_apb.psel && s_apb.penable && !(reg_hit && off_hi_zero);

endmodule

`default_nettype wire

// File: mtimer.sv
// ----------------------------------------------------------
// RISC-V machine timer on APB
// microsecond prescaler, 64-bit mtime and mtimecmp
// freeze on debug halt
// software and timer interrupt levels
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module mtimer
	import soc_pkg::*;
#(
	parameter int CLK_MHZ = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic i_dbg_halt,
	apb_if.slave s_apb,
	output logic o_soft_irq,
	output logic o_timer_irq
);

	localparam int PRESC_W = (CLK_MHZ > 1) ? $clog2(CLK_MHZ) : 1;

	logic [PRESC_W-1:0] presc_q;
	logic               tick;

	logic        ctrl_en_q;
	logic        msip_q;
	logic [63:0] mtime_q;
	logic [63:0] mtimecmp_q;
	logic        timer_irq_q;

	timer_reg_e reg_off;
	logic       off_hi_zero;
	logic       wr_en;
	logic       reg_hit;
	data_t      rdata;

	// ----------------------------------------------------------
	// prescaler, free running even under halt
	assign tick = (presc_q == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			presc_q <= PRESC_W'(CLK_MHZ - 1);
		end else if (tick) begin
			presc_q <= PRESC_W'(CLK_MHZ - 1);
		end else begin
			presc_q <= presc_q - 1'b1;
		end
	end

	// ----------------------------------------------------------
	// register access, zero wait states
	assign reg_off     = timer_reg_e'(s_apb.paddr[4:0]);
	assign off_hi_zero = ~|s_apb.paddr[ADDR_W-1:5];
	assign wr_en       = s_apb.psel && s_apb.penable && s_apb.pwrite && off_hi_zero;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en_q   <= 1'b1;
			msip_q      <= 1'b0;
			mtime_q     <= '0;
			mtimecmp_q  <= '1;
			timer_irq_q <= 1'b0;
		end else begin
			if (wr_en && reg_off == CTRL) begin
				ctrl_en_q <= s_apb.pwdata[0];
			end
			if (wr_en && reg_off == MSIP) begin
				msip_q <= s_apb.pwdata[0];
			end
			// bus write wins over the count
			if (wr_en && reg_off == MTIME) begin
				mtime_q[31:0] <= s_apb.pwdata;
			end else if (wr_en && reg_off == MTIMEH) begin
				mtime_q[63:32] <= s_apb.pwdata;
			end else if (tick && ctrl_en_q && !i_dbg_halt) begin
				mtime_q <= mtime_q + 64'd1;
			end
			if (wr_en && reg_off == MTIMECMP) begin
				mtimecmp_q[31:0] <= s_apb.pwdata;
			end
			if (wr_en && reg_off == MTIMECMPH) begin
				mtimecmp_q[63:32] <= s_apb.pwdata;
			end
			timer_irq_q <= (mtime_q >= mtimecmp_q);
		end
	end

	// read mux
	always_comb begin
		rdata   = '0;
		reg_hit = 1'b1;
		case (reg_off)
			CTRL:      rdata = {{(DATA_W-1){1'b0}}, ctrl_en_q};
			MSIP:      rdata = {{(DATA_W-1){1'b0}}, msip_q};
			MTIME:     rdata = mtime_q[31:0];
			MTIMEH:    rdata = mtime_q[63:32];
			MTIMECMP:  rdata = mtimecmp_q[31:0];
			MTIMECMPH: rdata = mtimecmp_q[63:32];
			default:   reg_hit = 1'b0;
		endcase
	end

	assign s_apb.prdata  = rdata;
	assign s_apb.pready  = 1'b1;
	assign s_apb.pslverr = s_apb.psel && s_apb.penable && !(reg_hit && off_hi_zero);

	// interrupt levels
	assign o_soft_irq  = msip_q;
	assign o_timer_irq = timer_irq_q;

endmodule

`default_nettype wire

// File: apb_splitter.sv
// ----------------------------------------------------------
// APB address decoder and response mux
// top address bits pick the timer or the uart
// unmapped space answers with an error on its own
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module apb_splitter
	import soc_pkg::*;
(
	apb_if.slave  s_apb,
	apb_if.master m_timer,
	apb_if.master m_uart
);

	localparam int SEL_W = SLV_SEL_MSB - SLV_SEL_LSB + 1;

	logic [SEL_W-1:0] sel_bits;
	slave_e           sel;
	addr_t            offset;

	data_t rsp_rdata;
	logic  rsp_ready;
	logic  rsp_err;

	// ----------------------------------------------------------
	// decode
	assign sel_bits = s_apb.paddr[SLV_SEL_MSB:SLV_SEL_LSB];

	always_comb begin
		if (sel_bits == TIMER_BASE[SLV_SEL_MSB:SLV_SEL_LSB]) begin
			sel = SLV_TIMER;
		end else if (sel_bits == UART_BASE[SLV_SEL_MSB:SLV_SEL_LSB]) begin
			sel = SLV_UART;
		end else begin
			sel = SLV_NONE;
		end
	end

	// slaves see only the offset inside their window
	assign offset = {{(ADDR_W-SLV_SEL_LSB){1'b0}}, s_apb.paddr[SLV_SEL_LSB-1:0]};

	// ----------------------------------------------------------
	// request fan-out, select only on the target
	assign m_timer.psel    = s_apb.psel && (sel == SLV_TIMER);
	assign m_timer.penable = s_apb.penable && (sel == SLV_TIMER);
	assign m_timer.pwrite  = s_apb.pwrite;
	assign m_timer.paddr   = offset;
	assign m_timer.pwdata  = s_apb.pwdata;

	assign m_uart.psel    = s_apb.psel && (sel == SLV_UART);
	assign m_uart.penable = s_apb.penable && (sel == SLV_UART);
	assign m_uart.pwrite  = s_apb.pwrite;
	assign m_uart.paddr   = offset;
	assign m_uart.pwdata  = s_apb.pwdata;

	// ----------------------------------------------------------
	// response mux
	always_comb begin
		case (sel)
			SLV_TIMER: begin
				rsp_rdata = m_timer.prdata;
				rsp_ready = m_timer.pready;
				rsp_err   = m_timer.pslverr;
			end
			SLV_UART: begin
				rsp_rdata = m_uart.prdata;
				rsp_ready = m_uart.pready;
				rsp_err   = m_uart.pslverr;
			end
			default: begin
				// unmapped, error in the first access cycle
				rsp_rdata = '0;
				rsp_ready = 1'b1;
				rsp_err   = 1'b1;
			end
		endcase
	end

	assign s_apb.prdata  = rsp_rdata;
	assign s_apb.pready  = rsp_ready;
	assign s_apb.pslverr = rsp_err;

endmodule

`default_nettype wire

// File: apb_bridge.sv
// ----------------------------------------------------------
// register-access port to APB bridge
// captures a one-cycle request strobe
// sequences the APB setup and access phases
// registers the response as a one-cycle pulse
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module apb_bridge
	import soc_pkg::*;
(
	input  logic clk,
	input  logic rst_n,

	// request port
	input  logic  i_req_valid,
	input  logic  i_req_write,
	input  addr_t i_req_addr,
	input  data_t i_req_wdata,

	// response port
	output logic  o_busy,
	output logic  o_rsp_valid,
	output data_t o_rsp_rdata,
	output logic  o_rsp_err,

	apb_if.master m_apb
);

	apb_state_e state_q;

	// request held stable through any stall
	logic  req_write_q;
	addr_t req_addr_q;
	data_t req_wdata_q;

	logic  rsp_valid_q;
	data_t rsp_rdata_q;
	logic  rsp_err_q;

	logic take_req;
	logic access_done;

	// strobes outside IDLE are dropped
	assign take_req    = (state_q == IDLE) && i_req_valid;
	assign access_done = (state_q == ACCESS) && m_apb.pready;

	// ----------------------------------------------------------
	// phase sequencer
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q     <= IDLE;
			rsp_valid_q <= 1'b0;
		end else begin
			// response is a single-cycle pulse
			rsp_valid_q <= access_done;
			case (state_q)
				IDLE: begin
					if (take_req) begin
						state_q <= SETUP;
					end
				end
				SETUP: begin
					state_q <= ACCESS;
				end
				ACCESS: begin
					// wait states last while pready is low
					if (m_apb.pready) begin
						state_q <= IDLE;
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// request capture and response data
	always_ff @(posedge clk) begin
		if (take_req) begin
			req_write_q <= i_req_write;
			req_addr_q  <= i_req_addr;
			req_wdata_q <= i_req_wdata;
		end
		if (access_done) begin
			// writes answer with zero data
			rsp_rdata_q <= req_write_q ? '0 : m_apb.prdata;
			rsp_err_q   <= m_apb.pslverr;
		end
	end

	// ----------------------------------------------------------
	// APB request side
	assign m_apb.psel    = (state_q != IDLE);
	assign m_apb.penable = (state_q == ACCESS);
	assign m_apb.pwrite  = req_write_q;
	assign m_apb.paddr   = req_addr_q;
	assign m_apb.pwdata  = req_wdata_q;

	// low again in the cycle the response shows
	assign o_busy      = (state_q != IDLE);
	assign o_rsp_valid = rsp_valid_q;
	assign o_rsp_rdata = rsp_rdata_q;
	assign o_rsp_err   = rsp_err_q;

endmodule

`default_nettype wire

// File: apb_if.sv
// ----------------------------------------------------------
// APB bus bundle between bridge, splitter and slaves
// master modport drives the request side
// slave modport drives the response side
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface apb_if
	import soc_pkg::*;
();

	// request side
	logic  psel;
	logic  penable;
	logic  pwrite;
	addr_t paddr;
	data_t pwdata;

	// response side, valid while pready is high in access
	data_t prdata;
	logic  pready;
	logic  pslverr;

	modport master (
		output psel, penable, pwrite, paddr, pwdata,
		input  prdata, pready, pslverr
	);

	modport slave (
		input  psel, penable, pwrite, paddr, pwdata,
		output prdata, pready, pslverr
	);

endinterface

`default_nettype wire

// File: soc_pkg.sv
// ----------------------------------------------------------
// shared definitions for the peripheral subsystem
// bus widths, address and data types
// bridge phase, slave select and register offset enums
// address map of the two APB slaves
// ----------------------------------------------------------
`default_nettype none

package soc_pkg;

	// bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 32;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// bridge phase
	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		SETUP  = 2'd1,
		ACCESS = 2'd2
	} apb_state_e;

	// decoded target of the splitter
	typedef enum logic [1:0] {
		SLV_TIMER = 2'd0,
		SLV_UART  = 2'd1,
		SLV_NONE  = 2'd2
	} slave_e;

	// ----------------------------------------------------------
	// address map
	// top two bits pick the slave, 2 and 3 are unmapped
	localparam int SLV_SEL_MSB = 15;
	localparam int SLV_SEL_LSB = 14;
	localparam addr_t TIMER_BASE = 16'h0000;
	localparam addr_t UART_BASE  = 16'h4000;

	// timer register offsets
	typedef enum logic [4:0] {
		CTRL      = 5'h00,
		MSIP      = 5'h04,
		MTIME     = 5'h08,
		MTIMEH    = 5'h0C,
		MTIMECMP  = 5'h10,
		MTIMECMPH = 5'h14
	} timer_reg_e;

	// uart register offsets
	typedef enum logic [3:0] {
		TXDATA = 4'h0,
		STATUS = 4'h4,
		DIV    = 4'h8
	} uart_reg_e;

endpackage

`default_nettype wire
